/* rv_mini_pkg.sv */
/*
 * Widths, opcodes, boot address and state encodings shared by the core.
 * Each RTL module takes these through a wildcard import in its header.
 */
package rv_mini_pkg;

  // Datapath and bus widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned BE_W       = 4;

  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 values that are decoded
  localparam logic [2:0] FUNCT3_SB  = 3'b000;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;

  // Access size for the load/store path
  typedef enum logic {
    MEM_WORD = 1'b0,
    MEM_BYTE = 1'b1
  } mem_size_e;

  // Instruction sequencer
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,
    ST_EXEC  = 3'd2,
    ST_MEM   = 3'd3,
    ST_HALT  = 3'd4
  } exec_state_e;

endpackage

/* rv_mini_fetch.sv */
/*
 * Instruction fetch path. Holds the PC, requests one word per fetch_start
 * on the shared bus and presents it with a one-cycle valid pulse.
 */
module rv_mini_fetch import rv_mini_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_start_i,
  input  logic            gnt_i,
  input  logic            rvalid_i,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            pc_next_en_i,
  input  logic            branch_taken_i,
  input  logic [XLEN-1:0] branch_target_i,
  output logic            req_o,
  output logic [XLEN-1:0] addr_o,
  output logic [XLEN-1:0] instr_o,
  output logic            instr_valid_o,
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;
  logic            req_q;
  logic [XLEN-1:0] instr_q;
  logic            instr_valid_q;

  // Next PC is either the branch target or the sequential word
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= BOOT_ADDR;
    end else if (pc_next_en_i) begin
      pc_q <= branch_taken_i ? branch_target_i : pc_q + XLEN'(4);
    end
  end

  // Request held from start until the bus grants it
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      instr_valid_q <= 1'b0;
    end else begin
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (gnt_i) begin
        req_q <= 1'b0;
      end
      instr_valid_q <= rvalid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid_i) begin
      instr_q <= rdata_i;
    end
  end

  assign req_o         = req_q;
  assign addr_o        = pc_q;
  assign pc_o          = pc_q;
  assign instr_o       = instr_q;
  assign instr_valid_o = instr_valid_q;

endmodule

/* rv_mini_exec.sv */
/*
 * Sequencer, decoder, adder and branch decision of the core.
 * Runs one instruction at a time and steers fetch, load/store and write-back.
 */
module rv_mini_exec import rv_mini_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic                  lsu_done_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  output logic                  fetch_start_o,
  output logic                  pc_next_en_o,
  output logic                  branch_taken_o,
  output logic [XLEN-1:0]       branch_target_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic                  rd_we_o,
  output logic [XLEN-1:0]       rd_wdata_o,
  output logic                  lsu_start_o,
  output logic                  lsu_we_o,
  output mem_size_e             lsu_size_o,
  output logic [XLEN-1:0]       lsu_addr_o,
  output logic [XLEN-1:0]       lsu_wdata_o,
  output logic                  halted_o
);

  exec_state_e     state_q, state_d;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
  logic [XLEN-1:0] alu_result;
  logic            is_alu, is_load, is_store, is_bne;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    is_alu     = 1'b0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    is_bne     = 1'b0;
    alu_result = rs1_data_i + imm_i;
    case (opcode)
      OPC_OP_IMM: is_alu = (funct3 == 3'b000);
      OPC_OP: begin
        is_alu     = (funct3 == 3'b000) && (funct7 == 7'b0);
        alu_result = rs1_data_i + rs2_data_i;
      end
      OPC_LUI: begin
        is_alu     = 1'b1;
        alu_result = imm_u;
      end
      OPC_LOAD:   is_load  = (funct3 == FUNCT3_LW);
      OPC_STORE:  is_store = (funct3 == FUNCT3_SW) || (funct3 == FUNCT3_SB);
      OPC_BRANCH: is_bne   = (funct3 == FUNCT3_BNE);
      default:    is_alu   = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    fetch_start_o = 1'b0;
    pc_next_en_o  = 1'b0;
    rd_we_o       = 1'b0;
    lsu_start_o   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (fetch_enable_i) begin
          fetch_start_o = 1'b1;
          state_d       = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (instr_valid_i) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (is_load || is_store) begin
          lsu_start_o = 1'b1;
          state_d     = ST_MEM;
        end else if (is_alu || is_bne) begin
          rd_we_o       = is_alu;
          pc_next_en_o  = 1'b1;
          fetch_start_o = 1'b1;
          state_d       = ST_FETCH;
        end else begin
          // ECALL and unknown encodings stop the core
          state_d = ST_HALT;
        end
      end
      ST_MEM: begin
        // Loads write back on the response cycle
        if (lsu_done_i) begin
          rd_we_o       = is_load;
          pc_next_en_o  = 1'b1;
          fetch_start_o = 1'b1;
          state_d       = ST_FETCH;
        end
      end
      default: state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];
  assign rd_wdata_o = (state_q == ST_MEM) ? lsu_rdata_i : alu_result;

  assign branch_taken_o  = is_bne && (rs1_data_i != rs2_data_i);
  assign branch_target_o = pc_i + imm_b;

  assign lsu_we_o    = is_store;
  assign lsu_size_o  = (is_store && (funct3 == FUNCT3_SB)) ? MEM_BYTE : MEM_WORD;
  assign lsu_addr_o  = rs1_data_i + (is_store ? imm_s : imm_i);
  assign lsu_wdata_o = rs2_data_i;
  assign halted_o    = (state_q == ST_HALT);

endmodule

/* rv_mini_regfile.sv */
/*
 * General purpose registers with two combinational read ports and one
 * write port. Register x0 always reads as zero.
 */
module rv_mini_regfile import rv_mini_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic                  we_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  logic [XLEN-1:0] rf_q [2**REG_ADDR_W];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_q <= '{default: '0};
    end else if (we_i && (waddr_i != '0)) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

/* rv_mini_lsu.sv */
/*
 * Load/store path. Turns an access from the sequencer into one bus request
 * with word address, byte enables and lane-replicated store data.
 */
module rv_mini_lsu import rv_mini_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            start_i,
  input  logic            we_i,
  input  mem_size_e       size_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            gnt_i,
  input  logic            rvalid_i,
  input  logic [XLEN-1:0] rdata_i,
  output logic            req_o,
  output logic [XLEN-1:0] addr_o,
  output logic            we_o,
  output logic [BE_W-1:0] be_o,
  output logic [XLEN-1:0] wdata_o,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o
);

  logic            req_q;
  logic [XLEN-1:0] addr_q;
  logic            we_q;
  logic [BE_W-1:0] be_q;
  logic [XLEN-1:0] wdata_q;
  logic [BE_W-1:0] be_d;
  logic [XLEN-1:0] wdata_d;

  // Byte access picks one lane and copies the byte to every lane
  always_comb begin
    if (size_i == MEM_BYTE) begin
      be_d    = BE_W'(1) << addr_i[1:0];
      wdata_d = {4{wdata_i[7:0]}};
    end else begin
      be_d    = '1;
      wdata_d = wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (start_i) begin
      req_q <= 1'b1;
    end else if (gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // Payload is captured once and held until the grant
  always_ff @(posedge clk) begin
    if (start_i) begin
      addr_q  <= {addr_i[XLEN-1:2], 2'b00};
      we_q    <= we_i;
      be_q    <= be_d;
      wdata_q <= wdata_d;
    end
  end

  assign req_o   = req_q;
  assign addr_o  = addr_q;
  assign we_o    = we_q;
  assign be_o    = be_q;
  assign wdata_o = wdata_q;

  // Response goes straight back to the sequencer
  assign done_o  = rvalid_i;
  assign rdata_o = rdata_i;

endmodule

/* rv_mini_bus_arbiter.sv */
/*
 * Shares the single memory port between fetch and load/store.
 * Load/store has priority, and one transaction is in flight at a time.
 */
module rv_mini_bus_arbiter import rv_mini_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_req_i,
  input  logic [XLEN-1:0] fetch_addr_i,
  input  logic            lsu_req_i,
  input  logic [XLEN-1:0] lsu_addr_i,
  input  logic            lsu_we_i,
  input  logic [BE_W-1:0] lsu_be_i,
  input  logic [XLEN-1:0] lsu_wdata_i,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  output logic            fetch_gnt_o,
  output logic            fetch_rvalid_o,
  output logic            lsu_gnt_o,
  output logic            lsu_rvalid_o,
  output logic            mem_req_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic            mem_we_o,
  output logic [BE_W-1:0] mem_be_o,
  output logic [XLEN-1:0] mem_wdata_o
);

  logic outstanding_q;
  logic owner_lsu_q;
  logic grant;

  // No new request goes out while a response is pending
  assign mem_req_o   = (fetch_req_i | lsu_req_i) & ~outstanding_q;
  assign mem_addr_o  = lsu_req_i ? lsu_addr_i : fetch_addr_i;
  assign mem_we_o    = lsu_req_i & lsu_we_i;
  assign mem_be_o    = lsu_req_i ? lsu_be_i : '1;
  assign mem_wdata_o = lsu_req_i ? lsu_wdata_i : '0;

  assign grant       = mem_req_o & mem_gnt_i;
  assign lsu_gnt_o   = grant & lsu_req_i;
  assign fetch_gnt_o = grant & ~lsu_req_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      owner_lsu_q   <= 1'b0;
    end else if (grant) begin
      outstanding_q <= 1'b1;
      owner_lsu_q   <= lsu_req_i;
    end else if (mem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // Response only reaches the peer that owns the transaction
  assign fetch_rvalid_o = mem_rvalid_i & outstanding_q & ~owner_lsu_q;
  assign lsu_rvalid_o   = mem_rvalid_i & outstanding_q & owner_lsu_q;

endmodule

/* rv_mini_core.sv */
/*
 * Top level of the multi-cycle core. Connects fetch, sequencer, register
 * file and load/store path to one req/gnt/rvalid memory port.
 */
module rv_mini_core import rv_mini_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  output logic            mem_req_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic            mem_we_o,
  output logic [BE_W-1:0] mem_be_o,
  output logic [XLEN-1:0] mem_wdata_o,
  output logic            core_sleep_o
);

  // Fetch side
  logic                  fetch_req, fetch_gnt, fetch_rvalid;
  logic [XLEN-1:0]       fetch_addr, instr, pc;
  logic                  instr_valid, fetch_start, pc_next_en, branch_taken;
  logic [XLEN-1:0]       branch_target;

  // Register file
  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data, rd_wdata;
  logic                  rd_we;

  // Load/store side
  logic                  lsu_start, lsu_we, lsu_done;
  mem_size_e             lsu_size;
  logic [XLEN-1:0]       lsu_addr, lsu_wdata, lsu_rdata;
  logic                  lsu_req, lsu_bus_we, lsu_gnt, lsu_rvalid;
  logic [XLEN-1:0]       lsu_bus_addr, lsu_bus_wdata;
  logic [BE_W-1:0]       lsu_bus_be;

  logic                  halted;
  logic                  core_sleep_q;

  //////////////////////////////////////////////////////////////////////
  // Core blocks
  //////////////////////////////////////////////////////////////////////

  rv_mini_fetch i_fetch (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .fetch_start_i   (fetch_start),
    .gnt_i           (fetch_gnt),
    .rvalid_i        (fetch_rvalid),
    .rdata_i         (mem_rdata_i),
    .pc_next_en_i    (pc_next_en),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .req_o           (fetch_req),
    .addr_o          (fetch_addr),
    .instr_o         (instr),
    .instr_valid_o   (instr_valid),
    .pc_o            (pc)
  );

  rv_mini_exec i_exec (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .fetch_enable_i  (fetch_enable_i),
    .instr_i         (instr),
    .instr_valid_i   (instr_valid),
    .pc_i            (pc),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .lsu_done_i      (lsu_done),
    .lsu_rdata_i     (lsu_rdata),
    .fetch_start_o   (fetch_start),
    .pc_next_en_o    (pc_next_en),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .rd_addr_o       (rd_addr),
    .rd_we_o         (rd_we),
    .rd_wdata_o      (rd_wdata),
    .lsu_start_o     (lsu_start),
    .lsu_we_o        (lsu_we),
    .lsu_size_o      (lsu_size),
    .lsu_addr_o      (lsu_addr),
    .lsu_wdata_o     (lsu_wdata),
    .halted_o        (halted)
  );

  rv_mini_regfile i_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .waddr_i   (rd_addr),
    .we_i      (rd_we),
    .wdata_i   (rd_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  rv_mini_lsu i_lsu (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .start_i  (lsu_start),
    .we_i     (lsu_we),
    .size_i   (lsu_size),
    .addr_i   (lsu_addr),
    .wdata_i  (lsu_wdata),
    .gnt_i    (lsu_gnt),
    .rvalid_i (lsu_rvalid),
    .rdata_i  (mem_rdata_i),
    .req_o    (lsu_req),
    .addr_o   (lsu_bus_addr),
    .we_o     (lsu_bus_we),
    .be_o     (lsu_bus_be),
    .wdata_o  (lsu_bus_wdata),
    .done_o   (lsu_done),
    .rdata_o  (lsu_rdata)
  );

  rv_mini_bus_arbiter i_arbiter (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .lsu_req_i      (lsu_req),
    .lsu_addr_i     (lsu_bus_addr),
    .lsu_we_i       (lsu_bus_we),
    .lsu_be_i       (lsu_bus_be),
    .lsu_wdata_i    (lsu_bus_wdata),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .fetch_gnt_o    (fetch_gnt),
    .fetch_rvalid_o (fetch_rvalid),
    .lsu_gnt_o      (lsu_gnt),
    .lsu_rvalid_o   (lsu_rvalid),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_we_o       (mem_we_o),
    .mem_be_o       (mem_be_o),
    .mem_wdata_o    (mem_wdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Sleep indication
  //////////////////////////////////////////////////////////////////////

  // Idle means halted or not yet enabled, with the bus quiet
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      core_sleep_q <= 1'b1;
    end else begin
      core_sleep_q <= (halted | ~fetch_enable_i) & ~mem_req_o;
    end
  end

  assign core_sleep_o = core_sleep_q;

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source. Makes a 40 ns clock and holds the
 * active-low reset for the first 16 cycles.
 */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // Released on a falling edge like the other DUT inputs
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_rv_mini_core.sv */
/*
 * Testbench for the core. Loads program, data and expected stores from
 * core_input.mem, models a req/gnt/rvalid memory with random grant delay
 * and checks every store, the bus protocol, start-up and halt.
 */
module tb_rv_mini_core import rv_mini_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned INPUT_WORDS      = 512;
  localparam int unsigned IMAGE_WORDS      = 256;
  localparam int unsigned HEADER_BASE      = 256;
  localparam int unsigned STORE_BASE       = 272;
  localparam int unsigned MAX_STORES       = 80;
  localparam int unsigned IDLE_CYCLES      = 10;
  localparam int unsigned POST_HALT_CYCLES = 20;
  localparam logic [31:0] RNG_SEED         = 32'h18a7;

  logic            clk;
  logic            rst_ni;
  logic            fetch_enable_i;
  logic            mem_gnt_i;
  logic            mem_rvalid_i;
  logic [XLEN-1:0] mem_rdata_i;
  logic            mem_req_o;
  logic [XLEN-1:0] mem_addr_o;
  logic            mem_we_o;
  logic [BE_W-1:0] mem_be_o;
  logic [XLEN-1:0] mem_wdata_o;
  logic            core_sleep_o;

  logic [31:0]     input_words [INPUT_WORDS];
  logic [XLEN-1:0] mem_image [IMAGE_WORDS];
  int unsigned     store_count;
  int unsigned     prog_len;
  int unsigned     timeout_limit = 0;
  bit              limit_ready = 1'b0;
  int unsigned     cycle_cnt = 0;
  int unsigned     stores_seen = 0;
  int unsigned     value_errors = 0;
  int unsigned     other_errors = 0;

  // Memory model state
  logic [31:0]     rng_state = RNG_SEED;
  int unsigned     grant_delay = 0;
  bit              delay_drawn = 1'b0;
  bit              resp_pending = 1'b0;
  logic [XLEN-1:0] resp_data = '0;
  bit              req_waiting = 1'b0;
  bit              first_req_seen = 1'b0;
  logic [XLEN-1:0] held_addr;
  logic            held_we;
  logic [BE_W-1:0] held_be;
  logic [XLEN-1:0] held_wdata;
  logic [XLEN-1:0] last_read_addr = '0;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_ni)
  );

  rv_mini_core i_dut (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_we_o       (mem_we_o),
    .mem_be_o       (mem_be_o),
    .mem_wdata_o    (mem_wdata_o),
    .core_sleep_o   (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word accesses use all lanes, byte stores exactly one
  function automatic bit is_legal_byte_enable(input logic [BE_W-1:0] be);
    case (be)
      4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic load_input_file();
    int unsigned i;
    for (i = 0; i < INPUT_WORDS; i++) begin
      input_words[i] = 32'hF000_0000 | i;
    end
    $readmemh("core_input.mem", input_words);
    for (i = 0; i < IMAGE_WORDS; i++) begin
      mem_image[i] = input_words[i];
    end
    store_count = input_words[HEADER_BASE];
    prog_len    = input_words[HEADER_BASE + 1];
    if (store_count > MAX_STORES || prog_len == 0 || prog_len > IMAGE_WORDS) begin
      $display("The header of core_input.mem is missing or out of range");
      other_errors++;
      store_count = 0;
      prog_len    = IMAGE_WORDS;
    end
    timeout_limit = 20 * prog_len * 12;
    limit_ready   = 1'b1;
  endtask

  task automatic print_error_counts();
    $display("Error counts: %0d wrong values, %0d other failures",
             value_errors, other_errors);
  endtask

  task automatic check_idle_outputs();
    assert (mem_req_o == 1'b0) else begin
      $display("FAILED mem_req_o: got %h, expected %h", mem_req_o, 1'b0);
      value_errors++;
    end
    assert (core_sleep_o == 1'b1) else begin
      $display("FAILED core_sleep_o: got %h, expected %h", core_sleep_o, 1'b1);
      value_errors++;
    end
  endtask

  task automatic check_first_request();
    assert (mem_we_o == 1'b0) else begin
      $display("FAILED mem_we_o: got %h, expected %h", mem_we_o, 1'b0);
      value_errors++;
    end
    assert (mem_addr_o == BOOT_ADDR) else begin
      $display("FAILED mem_addr_o: got %h, expected %h", mem_addr_o, BOOT_ADDR);
      value_errors++;
    end
  endtask

  // A waiting request must keep its payload until the grant
  task automatic check_request_held();
    assert (mem_req_o) else begin
      $display("A request was withdrawn before it was granted");
      other_errors++;
    end
    assert (mem_addr_o == held_addr) else begin
      $display("FAILED mem_addr_o: got %h, expected %h", mem_addr_o, held_addr);
      value_errors++;
    end
    assert (mem_we_o == held_we) else begin
      $display("FAILED mem_we_o: got %h, expected %h", mem_we_o, held_we);
      value_errors++;
    end
    assert (mem_be_o == held_be) else begin
      $display("FAILED mem_be_o: got %h, expected %h", mem_be_o, held_be);
      value_errors++;
    end
    assert (mem_wdata_o == held_wdata) else begin
      $display("FAILED mem_wdata_o: got %h, expected %h", mem_wdata_o, held_wdata);
      value_errors++;
    end
  endtask

  // Called in the cycle whose next rising edge completes the handshake
  task automatic serve_access();
    int unsigned     word_idx;
    int unsigned     entry;
    int unsigned     b;
    logic [XLEN-1:0] exp_addr;
    logic [BE_W-1:0] exp_be;
    logic [XLEN-1:0] exp_data;
    word_idx  = mem_addr_o[XLEN-1:2];
    resp_data = '0;
    if (mem_addr_o >= XLEN'(IMAGE_WORDS * 4)) begin
      $display("Access to address %h lies outside the memory image", mem_addr_o);
      other_errors++;
    end else if (mem_we_o) begin
      assert (stores_seen < store_count) else begin
        $display("Store to address %h came after the last expected store", mem_addr_o);
        other_errors++;
      end
      if (stores_seen < store_count) begin
        entry    = STORE_BASE + 3 * stores_seen;
        exp_addr = input_words[entry];
        exp_be   = input_words[entry + 1][BE_W-1:0];
        exp_data = input_words[entry + 2];
        assert (mem_addr_o == exp_addr) else begin
          $display("FAILED mem_addr_o: got %h, expected %h", mem_addr_o, exp_addr);
          value_errors++;
        end
        assert (mem_be_o == exp_be) else begin
          $display("FAILED mem_be_o: got %h, expected %h", mem_be_o, exp_be);
          value_errors++;
        end
        assert (mem_wdata_o == exp_data) else begin
          $display("FAILED mem_wdata_o: got %h, expected %h", mem_wdata_o, exp_data);
          value_errors++;
        end
      end
      assert (is_legal_byte_enable(mem_be_o)) else begin
        $display("Store used a byte enable that is neither one-hot nor full");
        other_errors++;
      end
      assert (mem_addr_o[1:0] == 2'b00) else begin
        $display("Store address was not word aligned");
        other_errors++;
      end
      stores_seen++;
      for (b = 0; b < BE_W; b++) begin
        if (mem_be_o[b]) begin
          mem_image[word_idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
        end
      end
    end else begin
      resp_data      = mem_image[word_idx];
      last_read_addr = mem_addr_o;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  initial begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    forever begin
      @(negedge clk);
      if (req_waiting) begin
        check_request_held();
      end
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
      req_waiting  = 1'b0;
      if (resp_pending) begin
        assert (!mem_req_o) else begin
          $display("A new request was raised while a response was outstanding");
          other_errors++;
        end
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = resp_data;
        resp_pending = 1'b0;
      end else if (mem_req_o) begin
        if (!first_req_seen) begin
          check_first_request();
          first_req_seen = 1'b1;
        end
        // Grant delay of 0 to 3 cycles per request
        if (!delay_drawn) begin
          rng_state   = next_xorshift(rng_state);
          grant_delay = rng_state % 4;
          delay_drawn = 1'b1;
        end
        if (grant_delay == 0) begin
          mem_gnt_i    = 1'b1;
          delay_drawn  = 1'b0;
          serve_access();
          resp_pending = 1'b1;
        end else begin
          grant_delay--;
          req_waiting = 1'b1;
          held_addr   = mem_addr_o;
          held_we     = mem_we_o;
          held_be     = mem_be_o;
          held_wdata  = mem_wdata_o;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    wait (limit_ready);
    while (cycle_cnt < timeout_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the core did not finish within %0d cycles", timeout_limit);
    other_errors++;
    print_error_counts();
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    fetch_enable_i = 1'b0;
    load_input_file();

    // Quiet bus and sleep during reset and while not enabled
    @(negedge clk);
    while (!rst_ni) begin
      check_idle_outputs();
      @(negedge clk);
    end
    repeat (IDLE_CYCLES) begin
      check_idle_outputs();
      @(negedge clk);
    end

    fetch_enable_i = 1'b1;
    @(negedge clk);
    assert (core_sleep_o == 1'b0) else begin
      $display("FAILED core_sleep_o: got %h, expected %h", core_sleep_o, 1'b0);
      value_errors++;
    end

    // Run until the core reports sleep after the ECALL
    while (!core_sleep_o) begin
      @(negedge clk);
    end

    assert (stores_seen == store_count) else begin
      $display("Only %0d of %0d expected stores were seen", stores_seen, store_count);
      other_errors++;
    end
    assert (last_read_addr == XLEN'((prog_len - 1) * 4)) else begin
      $display("FAILED mem_addr_o of the last fetch: got %h, expected %h",
               last_read_addr, XLEN'((prog_len - 1) * 4));
      value_errors++;
    end
    repeat (POST_HALT_CYCLES) begin
      @(negedge clk);
      assert (!mem_req_o) else begin
        $display("A bus request appeared after the core halted");
        other_errors++;
      end
      assert (core_sleep_o == 1'b1) else begin
        $display("FAILED core_sleep_o: got %h, expected %h", core_sleep_o, 1'b1);
        value_errors++;
      end
    end

    print_error_counts();
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* rv_mini_core.f */
rv_mini_pkg.sv
rv_mini_fetch.sv
rv_mini_exec.sv
rv_mini_regfile.sv
rv_mini_lsu.sv
rv_mini_bus_arbiter.sv
rv_mini_core.sv
tb_clock_gen.sv
tb_rv_mini_core.sv

/* core_input.mem */
// Hex words by index: @000 program and data image, @100 header (store count,
// program length), @110 expected stores with columns address, byte enable, data
@000
10000093 // addi x1, x0, 0x100
12345137 // lui  x2, 0x12345
67810193 // addi x3, x2, 0x678
00118233 // add  x4, x3, x1
0020A023 // sw   x2, 0(x1)
0030A223 // sw   x3, 4(x1)
0040A423 // sw   x4, 8(x1)
1A500293 // addi x5, x0, 0x1a5
085080A3 // sb   x5, 0x81(x1)
083081A3 // sb   x3, 0x83(x1)
0800A303 // lw   x6, 0x80(x1)
0060A623 // sw   x6, 12(x1)
00300393 // addi x7, x0, 3
01008413 // addi x8, x1, 16
00742023 // loop: sw x7, 0(x8)
00440413 // addi x8, x8, 4
FFF38393 // addi x7, x7, -1
FE039AE3 // bne  x7, x0, loop
FAB00493 // addi x9, x0, -85
00942023 // sw   x9, 0(x8)
00000073 // ecall
@060
11223344 // data word at 0x180, target of the byte stores
@100
0000000A // expected stores
00000015 // program length in instructions
@110
00000100 0000000F 12345000
00000104 0000000F 12345678
00000108 0000000F 12345778
00000180 00000002 A5A5A5A5
00000180 00000008 78787878
0000010C 0000000F 7822A544
00000110 0000000F 00000003
00000114 0000000F 00000002
00000118 0000000F 00000001
0000011C 0000000F FFFFFFAB
